// File: source/miss_path_defines.svh
`ifndef MISS_PATH_DEFINES_SVH
`define MISS_PATH_DEFINES_SVH

// ====================
// widths
// ====================
`define MP_ADDR_WIDTH 32
`define MP_DATA_WIDTH 64
`define MP_TID_WIDTH 3 // 8 ids.

// ====================
// depths
// ====================
`define MP_MAX_OUTSTANDING 8 // the whole tid space.
`define MP_RSP_DEPTH 4

`endif

// File: source/miss_path_pkg.sv
`include "miss_path_defines.svh"

package miss_path_pkg;

	// miss address from the core.
	typedef logic [`MP_ADDR_WIDTH-1:0] addr_t;

	// one word of returned memory data.
	typedef logic [`MP_DATA_WIDTH-1:0] data_t;

	// transaction id sent with the request and echoed back.
	typedef logic [`MP_TID_WIDTH-1:0] tid_t;

endpackage

// File: source/tid_counter.sv
`include "miss_path_defines.svh"

module tid_counter
	import miss_path_pkg::*;
(
	input  logic clk,
	input  logic rst_n,

	input  logic miss_i,
	input  logic drain_i,

	output tid_t alloc_tid_o,
	output logic busy_o
);

	localparam int CNT_W = $clog2(`MP_MAX_OUTSTANDING + 1);

	tid_t             tid_ptr;
	logic [CNT_W-1:0] out_cnt;

	// next free tid handed out in order.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tid_ptr <= '0;
		end else if (miss_i) begin
			tid_ptr <= tid_ptr + tid_t'(1); // wraps with the tid space.
		end
	end

	// outstanding misses drop when a response drains.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_cnt <= '0;
		end else begin
			case ({miss_i, drain_i})
				2'b10:   out_cnt <= out_cnt + CNT_W'(1);
				2'b01:   out_cnt <= out_cnt - CNT_W'(1);
				default: out_cnt <= out_cnt; // none or both.
			endcase
		end
	end

	assign alloc_tid_o = tid_ptr;
	assign busy_o      = (out_cnt == CNT_W'(`MP_MAX_OUTSTANDING));

	// ====================
	// checks
	// ====================
	a_no_miss_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n) miss_i |-> !busy_o
	) else $error("miss strobe while all tids are in flight");

	a_no_drain_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n) drain_i |-> (out_cnt != '0)
	) else $error("response drained with no miss outstanding");

endmodule

// File: source/miss_fifo.sv
`include "miss_path_defines.svh"

module miss_fifo
	import miss_path_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	input  logic  push_i,
	input  addr_t push_addr_i,
	input  tid_t  push_tid_i,

	input  logic  pop_i,
	output logic  empty_o,
	output addr_t head_addr_o,
	output tid_t  head_tid_o,

	output logic  mem_req_o,
	output addr_t mem_req_addr_o,
	output tid_t  mem_req_tid_o
);

	localparam int DEPTH = `MP_MAX_OUTSTANDING;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	addr_t            addr_mem [DEPTH];
	tid_t             tid_mem  [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;

	assign full    = (count == CNT_W'(DEPTH));
	assign empty_o = (count == '0);

	// ====================
	// pointers and count
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (pop_i)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			if (push_i && !pop_i)
				count <= count + CNT_W'(1);
			else if (pop_i && !push_i)
				count <= count - CNT_W'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			addr_mem[wr_ptr] <= push_addr_i;
			tid_mem[wr_ptr]  <= push_tid_i;
		end
	end

	assign head_addr_o = addr_mem[rd_ptr];
	assign head_tid_o  = tid_mem[rd_ptr];

	// ====================
	// memory request
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n)
			mem_req_o <= 1'b0;
		else
			mem_req_o <= push_i; // one cycle behind the miss.
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem_req_addr_o <= push_addr_i;
			mem_req_tid_o  <= push_tid_i;
		end
	end

	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o
	) else $error("miss queue popped while empty");

	a_no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n) push_i |-> !full
	) else $error("miss queue pushed while full");

endmodule

// File: source/read_miss_handler.sv
module read_miss_handler
	import miss_path_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	// memory return.
	input  logic  valid_i,
	output logic  ready_o,
	input  data_t data_i,
	input  tid_t  rid_i,

	// miss queue head.
	input  logic  empty_i,
	input  addr_t head_addr_i,
	input  tid_t  head_tid_i,
	output logic  pop_o,

	// response queue write.
	input  logic  full_i,
	output logic  wr_en_o,
	output tid_t  wr_tid_o,
	output data_t wr_data_o,

	// fill to the arbiter.
	output logic  fill_valid_o,
	input  logic  fill_ready_i,
	output addr_t fill_addr_o,
	output data_t fill_data_o
);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_FILL = 2'd1;
	localparam logic [1:0] S_WAIT = 2'd2; // response written and the queue may be full.

	logic [1:0] state;
	logic [1:0] state_n;
	logic       accept;
	addr_t      addr_q;
	tid_t       tid_q;
	data_t      data_q;

	// open again once the queue has room after a write.
	assign ready_o = (state == S_IDLE) || ((state == S_WAIT) && !full_i);
	assign accept  = valid_i && ready_o;
	assign pop_o   = accept;

	// ====================
	// state
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= state_n;
	end

	always_comb begin
		state_n = state;
		wr_en_o = 1'b0;
		case (state)
			S_IDLE: begin
				if (accept)
					state_n = S_FILL;
			end
			S_FILL: begin
				if (fill_ready_i) begin
					wr_en_o = 1'b1; // same cycle as the fill transfer.
					state_n = S_WAIT;
				end
			end
			S_WAIT: begin
				if (accept)
					state_n = S_FILL;
				else if (!full_i)
					state_n = S_IDLE;
			end
			default: state_n = S_IDLE;
		endcase
	end

	// ====================
	// latched return
	// ====================
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= head_addr_i;
			tid_q  <= head_tid_i;
			data_q <= data_i;
		end
	end

	assign fill_valid_o = (state == S_FILL);
	assign fill_addr_o  = addr_q;
	assign fill_data_o  = data_q;
	assign wr_tid_o     = tid_q;
	assign wr_data_o    = data_q;

	a_return_has_miss: assert property (
		@(posedge clk) disable iff (!rst_n) valid_i |-> !empty_i
	) else $error("memory return with no queued miss");

	a_rid_in_order: assert property (
		@(posedge clk) disable iff (!rst_n) accept |-> (rid_i == head_tid_i)
	) else $error("memory return id does not match the oldest miss");

endmodule

// File: source/rsp_queue.sv
`include "miss_path_defines.svh"

module rsp_queue
	import miss_path_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	input  logic  wr_en_i,
	input  tid_t  wr_tid_i,
	input  data_t wr_data_i,
	output logic  full_o,

	output logic  rsp_valid_o,
	input  logic  rsp_ready_i,
	output tid_t  rsp_tid_o,
	output data_t rsp_data_o,

	output logic  drain_o
);

	localparam int DEPTH = `MP_RSP_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	tid_t             tid_mem  [DEPTH];
	data_t            data_mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign full_o      = (count == CNT_W'(DEPTH));
	assign rsp_valid_o = (count != '0);
	assign drain_o     = rsp_valid_o && rsp_ready_i;

	// ====================
	// occupancy
	// ====================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en_i)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
			if (drain_o)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
			case ({wr_en_i, drain_o})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	// ====================
	// storage
	// ====================
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tid_mem[wr_ptr]  <= wr_tid_i;
			data_mem[wr_ptr] <= wr_data_i;
		end
	end

	// head entry stays stable until it drains.
	assign rsp_tid_o  = tid_mem[rd_ptr];
	assign rsp_data_o = data_mem[rd_ptr];

	a_no_write_full: assert property (
		@(posedge clk) disable iff (!rst_n) wr_en_i |-> !full_o
	) else $error("response queue written while full");

endmodule

// File: source/miss_path_top.sv
module miss_path_top
	import miss_path_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,

	// miss request from the core.
	input  logic  miss_i,
	input  addr_t miss_addr_i,
	output logic  miss_busy_o,

	// memory request.
	output logic  mem_req_o,
	output addr_t mem_req_addr_o,
	output tid_t  mem_req_tid_o,

	// memory return.
	input  logic  mem_valid_i,
	output logic  mem_ready_o,
	input  data_t mem_data_i,
	input  tid_t  mem_rid_i,

	// fill to the arbiter.
	output logic  fill_valid_o,
	input  logic  fill_ready_i,
	output addr_t fill_addr_o,
	output data_t fill_data_o,

	// response to the core.
	output logic  rsp_valid_o,
	input  logic  rsp_ready_i,
	output tid_t  rsp_tid_o,
	output data_t rsp_data_o
);

	tid_t  alloc_tid;
	addr_t head_addr;
	tid_t  head_tid;
	logic  empty;
	logic  pop;
	logic  wr_en;
	tid_t  wr_tid;
	data_t wr_data;
	logic  full;
	logic  drain;

	tid_counter u_tid_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.miss_i      (miss_i),
		.drain_i     (drain),
		.alloc_tid_o (alloc_tid),
		.busy_o      (miss_busy_o)
	);

	miss_fifo u_miss_fifo (
		.clk            (clk),
		.rst_n          (rst_n),
		.push_i         (miss_i),
		.push_addr_i    (miss_addr_i),
		.push_tid_i     (alloc_tid),
		.pop_i          (pop),
		.empty_o        (empty),
		.head_addr_o    (head_addr),
		.head_tid_o     (head_tid),
		.mem_req_o      (mem_req_o),
		.mem_req_addr_o (mem_req_addr_o),
		.mem_req_tid_o  (mem_req_tid_o)
	);

	read_miss_handler u_read_miss_handler (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_i      (mem_valid_i),
		.ready_o      (mem_ready_o),
		.data_i       (mem_data_i),
		.rid_i        (mem_rid_i),
		.empty_i      (empty),
		.head_addr_i  (head_addr),
		.head_tid_i   (head_tid),
		.pop_o        (pop),
		.full_i       (full),
		.wr_en_o      (wr_en),
		.wr_tid_o     (wr_tid),
		.wr_data_o    (wr_data),
		.fill_valid_o (fill_valid_o),
		.fill_ready_i (fill_ready_i),
		.fill_addr_o  (fill_addr_o),
		.fill_data_o  (fill_data_o)
	);

	rsp_queue u_rsp_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_en_i     (wr_en),
		.wr_tid_i    (wr_tid),
		.wr_data_i   (wr_data),
		.full_o      (full),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_tid_o   (rsp_tid_o),
		.rsp_data_o  (rsp_data_o),
		.drain_o     (drain)
	);

endmodule

// File: dv/clk_gen.sv
module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end
endmodule

// File: dv/tb_miss_path.sv
`include "miss_path_defines.svh"

module tb_miss_path
	import miss_path_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ROWS        = 12;
	localparam int BURST_ROWS      = `MP_MAX_OUTSTANDING; // fills every tid.
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 60;

	logic  clk;
	logic  rst_n;
	logic  miss_i       = 1'b0;
	addr_t miss_addr_i  = '0;
	logic  mem_valid_i  = 1'b0;
	data_t mem_data_i   = '0;
	tid_t  mem_rid_i    = '0;
	logic  fill_ready_i = 1'b0;
	logic  rsp_ready_i  = 1'b0;
	logic  miss_busy_o, mem_req_o, mem_ready_o, fill_valid_o, rsp_valid_o;
	addr_t mem_req_addr_o, fill_addr_o;
	tid_t  mem_req_tid_o, rsp_tid_o;
	data_t fill_data_o, rsp_data_o;

	// ====================
	// stimulus table
	// ====================
	addr_t row_addr       [NUM_ROWS];
	data_t row_data       [NUM_ROWS];
	tid_t  row_tid        [NUM_ROWS];
	int    row_fill_stall [NUM_ROWS];
	int    row_rsp_stall  [NUM_ROWS];

	int   seed      = 18071;
	int   req_idx   = 0;
	int   ret_idx   = 0;
	int   fill_idx  = 0;
	int   rsp_idx   = 0;
	int   fill_gap  = 0;
	int   rsp_gap   = 0;
	int   queued    = 0; // responses sitting in the queue.
	logic miss_d    = 1'b0;
	logic full_seen = 1'b0;
	logic core_hold = 1'b1;
	logic fill_held = 1'b0; // fill offered and not yet taken.
	tid_t pending_tid [$];

	clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk_gen (.clk(clk), .rst_n(rst_n));

	miss_path_top UUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.miss_i         (miss_i),
		.miss_addr_i    (miss_addr_i),
		.miss_busy_o    (miss_busy_o),
		.mem_req_o      (mem_req_o),
		.mem_req_addr_o (mem_req_addr_o),
		.mem_req_tid_o  (mem_req_tid_o),
		.mem_valid_i    (mem_valid_i),
		.mem_ready_o    (mem_ready_o),
		.mem_data_i     (mem_data_i),
		.mem_rid_i      (mem_rid_i),
		.fill_valid_o   (fill_valid_o),
		.fill_ready_i   (fill_ready_i),
		.fill_addr_o    (fill_addr_o),
		.fill_data_o    (fill_data_o),
		.rsp_valid_o    (rsp_valid_o),
		.rsp_ready_i    (rsp_ready_i),
		.rsp_tid_o      (rsp_tid_o),
		.rsp_data_o     (rsp_data_o)
	);

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
	                           input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
			         expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "check failed");
		end
	endtask

	function automatic void build_table();
		for (int i = 0; i < NUM_ROWS; i++) begin
			row_addr[i]       = addr_t'($random(seed)) & ~addr_t'(63); // line aligned.
			row_data[i]       = {$random(seed), $random(seed)};
			row_tid[i]        = tid_t'(i % (1 << `MP_TID_WIDTH));
			row_fill_stall[i] = {$random(seed)} % 5;
			row_rsp_stall[i]  = {$random(seed)} % 4;
		end
	endfunction

	// ====================
	// models
	// ====================
	// memory returns in issue order.
	always @(posedge clk) begin
		if (rst_n) begin
			if (mem_req_o)
				pending_tid.push_back(mem_req_tid_o);
			if (mem_valid_i && mem_ready_o) begin
				ret_idx++;
				mem_valid_i <= 1'b0;
			end else if (!mem_valid_i && pending_tid.size() > 0) begin
				mem_valid_i <= 1'b1;
				mem_rid_i   <= pending_tid.pop_front();
				mem_data_i  <= row_data[ret_idx];
			end
		end
	end

	// arbiter checks every cycle the fill is offered.
	always @(posedge clk) begin
		if (!rst_n) begin
			fill_gap = row_fill_stall[0];
		end else begin
			check_value(64'(fill_valid_o || !fill_held), 64'(1),
			            "fill_valid_o dropped before fill_ready_i");
			fill_held = fill_valid_o && !fill_ready_i;
			if (fill_valid_o) begin
				check_value(64'(fill_idx < NUM_ROWS), 64'(1), "fill beyond the last row");
				check_value(64'(fill_addr_o), 64'(row_addr[fill_idx]), "fill address");
				check_value(fill_data_o, row_data[fill_idx], "fill data");
				if (fill_ready_i) begin
					fill_idx++;
					fill_ready_i <= 1'b0;
					if (fill_idx < NUM_ROWS)
						fill_gap = row_fill_stall[fill_idx];
				end else if (fill_gap > 0) begin
					fill_gap--;
				end else begin
					fill_ready_i <= 1'b1;
				end
			end
		end
	end

	// core drains responses.
	always @(posedge clk) begin
		if (!rst_n) begin
			rsp_gap = row_rsp_stall[0];
		end else if (rsp_valid_o && rsp_ready_i) begin
			check_value(64'(rsp_idx < NUM_ROWS), 64'(1), "response beyond the last row");
			check_value(64'(rsp_tid_o), 64'(row_tid[rsp_idx]), "response tid");
			check_value(rsp_data_o, row_data[rsp_idx], "response data");
			rsp_idx++;
			rsp_ready_i <= 1'b0;
			if (rsp_idx < NUM_ROWS)
				rsp_gap = row_rsp_stall[rsp_idx];
		end else if (rsp_valid_o && !core_hold) begin
			if (rsp_gap > 0)
				rsp_gap--;
			else
				rsp_ready_i <= 1'b1;
		end
	end

	// request timing and queue back-pressure.
	always @(posedge clk) begin
		if (rst_n) begin
			check_value(64'(mem_req_o), 64'(miss_d), "memory request one cycle after the miss");
			if (mem_req_o) begin
				check_value(64'(mem_req_addr_o), 64'(row_addr[req_idx]), "request address");
				check_value(64'(mem_req_tid_o), 64'(row_tid[req_idx]), "request tid");
				req_idx++;
			end
			if (queued == `MP_RSP_DEPTH)
				check_value(64'(mem_ready_o), 64'(0), "mem_ready_o with the response queue full");
			queued = queued + int'(fill_valid_o && fill_ready_i) - int'(rsp_valid_o && rsp_ready_i);
			if (queued == `MP_RSP_DEPTH)
				full_seen = 1'b1;
			miss_d = miss_i;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ====================
	// main sequence
	// ====================
	initial begin
		int gap;
		build_table();

		wait (rst_n);
		@(posedge clk);
		check_value(64'(mem_req_o), 64'(0), "mem_req_o after reset");
		check_value(64'(fill_valid_o), 64'(0), "fill_valid_o after reset");
		check_value(64'(rsp_valid_o), 64'(0), "rsp_valid_o after reset");
		check_value(64'(miss_busy_o), 64'(0), "miss_busy_o after reset");
		check_value(64'(mem_ready_o), 64'(1), "mem_ready_o after reset");

		// back to back misses with the core stalled.
		for (int i = 0; i < BURST_ROWS; i++) begin
			@(posedge clk);
			miss_i      <= 1'b1;
			miss_addr_i <= row_addr[i];
		end
		@(posedge clk);
		miss_i <= 1'b0;
		@(posedge clk);
		check_value(64'(miss_busy_o), 64'(1), "miss_busy_o with every tid in flight");
		wait (full_seen);
		repeat (4) @(posedge clk);
		check_value(64'(miss_busy_o), 64'(1), "miss_busy_o before any drain");
		core_hold <= 1'b0;
		@(posedge clk);
		while (!(rsp_valid_o && rsp_ready_i))
			@(posedge clk);
		@(posedge clk);
		check_value(64'(miss_busy_o), 64'(0), "miss_busy_o after a drain");

		for (int i = BURST_ROWS; i < NUM_ROWS; i++) begin
			gap = {$random(seed)} % 3;
			repeat (gap) @(posedge clk);
			@(posedge clk);
			while (miss_busy_o)
				@(posedge clk);
			miss_i      <= 1'b1;
			miss_addr_i <= row_addr[i];
			@(posedge clk);
			miss_i <= 1'b0;
		end

		wait (rsp_idx == NUM_ROWS);
		repeat (2) @(posedge clk);
		check_value(64'(req_idx), 64'(NUM_ROWS), "memory request count");
		check_value(64'(fill_idx), 64'(NUM_ROWS), "fill count");
		check_value(64'(rsp_valid_o), 64'(0), "rsp_valid_o once drained");
		check_value(64'(miss_busy_o), 64'(0), "miss_busy_o once drained");
		check_value(64'(mem_ready_o), 64'(1), "mem_ready_o once drained");
		$display("ALL TESTS PASSED");
		$finish;
	end
endmodule

// File: miss_path.f
+incdir+source
source/miss_path_pkg.sv
source/tid_counter.sv
source/miss_fifo.sv
source/read_miss_handler.sv
source/rsp_queue.sv
source/miss_path_top.sv
dv/clk_gen.sv
dv/tb_miss_path.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_miss_path
FILELIST  := miss_path.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "SOME TESTS FAILED" $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
